// File: src/itag_hit_detect.sv
`timescale 1ns/1ps

module itag_hit_detect
  import itag_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  itag_lookup_t lookup_i,
  input  itag_read_t   rd_i,
  output itag_result_t result_o
);

  logic [ICACHE_N_WAY-1:0] way_match;
  logic                    any_hit;

  logic                    result_valid_q;
  logic                    result_hit_q;
  logic [ICACHE_N_WAY-1:0] result_way_q;

  // Tag compare per way, only valid entries count
  always_comb begin
    for (int w = 0; w < ICACHE_N_WAY; w++) begin
      way_match[w] = rd_i.way_vbit[w] && (rd_i.way_tag[w] == lookup_i.tag);
    end
  end

  assign any_hit = |way_match;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= lookup_i.valid;
    end
  end

  // Way is zero on a miss since no bit matched
  always_ff @(posedge clk_i) begin
    if (lookup_i.valid) begin
      result_hit_q <= any_hit;
      result_way_q <= way_match;
    end
  end

  assign result_o.valid = result_valid_q;
  assign result_o.hit   = result_hit_q;
  assign result_o.way   = result_way_q;

endmodule

// File: src/itag_memory.sv
`timescale 1ns/1ps

module itag_memory
  import itag_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          flush_i,
  input  itag_mem_req_t req_i,
  output itag_read_t    rd_o
);

  localparam int unsigned WORD_WIDTH = ICACHE_N_WAY * TAG_WIDTH;

  logic [ICACHE_DEPTH-1:0] vbit_vec [ICACHE_N_WAY];
  logic                    vbit_q   [ICACHE_N_WAY];

  logic [WORD_WIDTH-1:0] lane_mask;
  logic [WORD_WIDTH-1:0] wmask;
  logic [WORD_WIDTH-1:0] wdata;
  logic [WORD_WIDTH-1:0] tag_q;
  logic                  chip_en;

  for (genvar w = 0; w < ICACHE_N_WAY; w++) begin : g_way
    // Valid bits live in flops so a flush clears them in one cycle
    always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
        vbit_vec[w] <= '0;
        vbit_q[w]   <= 1'b0;  // Lookup during flush sees cleared state
      end else if (req_i.way_req[w]) begin
        if (req_i.we) begin
          vbit_vec[w][req_i.index] <= req_i.vbit;
        end else begin
          vbit_q[w] <= vbit_vec[w][req_i.index];
        end
      end
    end

    assign lane_mask[w*TAG_WIDTH +: TAG_WIDTH] = {TAG_WIDTH{req_i.way_req[w]}};

    // Unpack array word into way tags
    assign rd_o.way_tag[w]  = tag_q[w*TAG_WIDTH +: TAG_WIDTH];
    assign rd_o.way_vbit[w] = vbit_q[w];
  end

  // Same tag in every lane, the mask picks the way
  assign wdata   = {ICACHE_N_WAY{req_i.wtag}};
  assign wmask   = lane_mask & {WORD_WIDTH{req_i.we}};
  assign chip_en = |req_i.way_req;

  itag_sram i_itag_sram (
    .clk_i   (clk_i),
    .ce_i    (chip_en),
    .we_i    (req_i.we),
    .addr_i  (req_i.index),
    .wmask_i (wmask),
    .wdata_i (wdata),
    .q_o     (tag_q)
  );

endmodule

// File: src/itag_pkg.sv
package itag_pkg;

  // Cache geometry
  localparam int unsigned ICACHE_N_WAY = 4;
  localparam int unsigned ICACHE_DEPTH = 64;
  localparam int unsigned INDEX_WIDTH  = 6;
  localparam int unsigned OFFSET_WIDTH = 6;
  localparam int unsigned TAG_WIDTH    = 20;
  localparam int unsigned VADDR_WIDTH  = 32;

  // Fetch address split into its fields, tag in the upper bits
  typedef struct packed {
    logic [TAG_WIDTH-1:0]    tag;
    logic [INDEX_WIDTH-1:0]  index;
    logic [OFFSET_WIDTH-1:0] offset;
  } itag_addr_t;

  typedef struct packed {
    logic [ICACHE_N_WAY-1:0] way_req;  // One bit per way
    logic                    we;
    logic                    vbit;     // Valid value on a write
    logic [INDEX_WIDTH-1:0]  index;
    logic [TAG_WIDTH-1:0]    wtag;
  } itag_mem_req_t;

  typedef struct packed {
    logic                 valid;
    logic [TAG_WIDTH-1:0] tag;
  } itag_lookup_t;

  typedef struct packed {
    logic [ICACHE_N_WAY-1:0][TAG_WIDTH-1:0] way_tag;
    logic [ICACHE_N_WAY-1:0]                way_vbit;
  } itag_read_t;

  typedef struct packed {
    logic                    valid;
    logic                    hit;
    logic [ICACHE_N_WAY-1:0] way;  // One-hot, zero on miss
  } itag_result_t;

endpackage

// File: src/itag_req_decode.sv
`timescale 1ns/1ps

module itag_req_decode
  import itag_pkg::*;
(
  input  logic          clk_i,
  input  logic          reset_i,
  input  logic          lookup_i,
  input  itag_addr_t    addr_i,
  input  logic          fill_i,
  input  itag_addr_t    fill_addr_i,
  output itag_mem_req_t mem_req_o,
  output itag_lookup_t  lookup_o
);

  localparam int unsigned PTR_WIDTH = $clog2(ICACHE_N_WAY);

  logic [PTR_WIDTH-1:0]    repl_ptr;
  logic [ICACHE_N_WAY-1:0] fill_way;
  logic                    lookup_go;
  logic                    lookup_valid_q;
  logic [TAG_WIDTH-1:0]    lookup_tag_q;

  // Way picked for the next fill
  assign fill_way = {{(ICACHE_N_WAY-1){1'b0}}, 1'b1} << repl_ptr;

  // A fill in the same cycle drops the lookup
  assign lookup_go = lookup_i & ~fill_i;

  always_comb begin
    mem_req_o = '0;
    if (fill_i) begin
      mem_req_o.way_req = fill_way;
      mem_req_o.we      = 1'b1;
      mem_req_o.vbit    = 1'b1;
      mem_req_o.index   = fill_addr_i.index;
      mem_req_o.wtag    = fill_addr_i.tag;
    end else if (lookup_i) begin
      mem_req_o.way_req = '1;  // Read all ways
      mem_req_o.index   = addr_i.index;
    end
  end

  // Global round-robin pointer, wraps after the last way
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      repl_ptr <= '0;
    end else if (fill_i) begin
      repl_ptr <= repl_ptr + 1'b1;
    end
  end

  // Lookup flag lines up with the array read data
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lookup_valid_q <= 1'b0;
    end else begin
      lookup_valid_q <= lookup_go;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lookup_go) begin
      lookup_tag_q <= addr_i.tag;
    end
  end

  assign lookup_o.valid = lookup_valid_q;
  assign lookup_o.tag   = lookup_tag_q;

endmodule

// File: src/itag_sram.sv
`timescale 1ns/1ps

module itag_sram
  import itag_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                ce_i,
  input  logic                                we_i,
  input  logic [INDEX_WIDTH-1:0]              addr_i,
  input  logic [ICACHE_N_WAY*TAG_WIDTH-1:0]   wmask_i,
  input  logic [ICACHE_N_WAY*TAG_WIDTH-1:0]   wdata_i,
  output logic [ICACHE_N_WAY*TAG_WIDTH-1:0]   q_o
);

  localparam int unsigned WORD_WIDTH = ICACHE_N_WAY * TAG_WIDTH;

  // Behavioural model of the single-port macro
  logic [WORD_WIDTH-1:0] mem [ICACHE_DEPTH];
  logic [WORD_WIDTH-1:0] word;

  assign word = mem[addr_i];

  always_ff @(posedge clk_i) begin
    if (ce_i && we_i) begin
      // Masked bits take new data, the rest keep their value
      mem[addr_i] <= (word & ~wmask_i) | (wdata_i & wmask_i);
    end
  end

  // Output register holds its value when no read is issued
  always_ff @(posedge clk_i) begin
    if (ce_i && !we_i) begin
      q_o <= word;
    end
  end

endmodule

// File: src/itag_top.sv
`timescale 1ns/1ps

module itag_top
  import itag_pkg::*;
(
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         lookup_i,
  input  itag_addr_t   addr_i,
  input  logic         fill_i,
  input  itag_addr_t   fill_addr_i,
  input  logic         flush_i,
  output itag_result_t result_o
);

  itag_mem_req_t mem_req;   // Combinational, same cycle as the strobe
  itag_lookup_t  lookup_q;  // One cycle later, beside the read data
  itag_read_t    rd;

  itag_req_decode i_itag_req_decode (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lookup_i    (lookup_i),
    .addr_i      (addr_i),
    .fill_i      (fill_i),
    .fill_addr_i (fill_addr_i),
    .mem_req_o   (mem_req),
    .lookup_o    (lookup_q)
  );

  itag_memory i_itag_memory (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .flush_i (flush_i),
    .req_i   (mem_req),
    .rd_o    (rd)
  );

  itag_hit_detect i_itag_hit_detect (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .lookup_i (lookup_q),
    .rd_i     (rd),
    .result_o (result_o)
  );

endmodule

// File: tb.f
src/itag_pkg.sv
src/itag_req_decode.sv
src/itag_sram.sv
src/itag_memory.sv
src/itag_hit_detect.sv
src/itag_top.sv
tests/tb_itag_top.sv

// File: tests/tb_itag_top.sv
`timescale 1ns/1ps

module tb_itag_top
  import itag_pkg::*;
();

  // Cycle budget per test, reset first, then in test order
  localparam int  TEST_CYCLES = 3 + 13 + 11 + 5 + 24 + 13 + 5;
  localparam time WATCHDOG_NS = TEST_CYCLES * 100 + 2000;

  logic         clk_i;
  logic         reset_i;
  logic         lookup_i;
  itag_addr_t   addr_i;
  logic         fill_i;
  itag_addr_t   fill_addr_i;
  logic         flush_i;
  itag_result_t result_o;

  // Reference model of tags, valid bits and the global pointer
  logic [TAG_WIDTH-1:0] tag_m [ICACHE_DEPTH][ICACHE_N_WAY];
  logic                 vld_m [ICACHE_DEPTH][ICACHE_N_WAY];
  int                   ptr_m;

  // Expected result of the lookup sampled at the last edge
  logic                    exp_valid_q;
  logic                    exp_hit_q;
  logic [ICACHE_N_WAY-1:0] exp_way_q;

  logic [31:0]          lfsr_state;
  int                   pass_cnt;
  int                   err_cnt;
  int                   test_err_start;
  string                cur_test;
  logic [INDEX_WIDTH-1:0] set_a;
  logic [TAG_WIDTH-1:0] tags_a [ICACHE_N_WAY];

  itag_top i_itag_top (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .lookup_i    (lookup_i),
    .addr_i      (addr_i),
    .fill_i      (fill_i),
    .fill_addr_i (fill_addr_i),
    .flush_i     (flush_i),
    .result_o    (result_o)
  );

  always #50 clk_i = ~clk_i;

  // Galois LFSR, one step per output bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [TAG_WIDTH-1:0] rand_tag();
    return TAG_WIDTH'(rand_bits(TAG_WIDTH));
  endfunction

  function automatic logic [INDEX_WIDTH-1:0] rand_index();
    return INDEX_WIDTH'(rand_bits(INDEX_WIDTH));
  endfunction

  function automatic itag_addr_t make_addr(input logic [TAG_WIDTH-1:0] tag,
                                           input logic [INDEX_WIDTH-1:0] index);
    itag_addr_t a;
    a.tag    = tag;
    a.index  = index;
    a.offset = OFFSET_WIDTH'(rand_bits(OFFSET_WIDTH));  // Offset must not matter
    return a;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s: %s got %0h expected %0h", $time, cur_test, msg, got, exp);
      err_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Drive one cycle, update the model and check the result due now
  task automatic run_cycle(input logic lk, input itag_addr_t la, input logic fl,
                           input itag_addr_t fa, input logic fs);
    logic                    e_valid;
    logic [ICACHE_N_WAY-1:0] e_way;
    logic                    o_valid;
    logic                    o_hit;
    logic [ICACHE_N_WAY-1:0] o_way;
    lookup_i    = lk;
    addr_i      = la;
    fill_i      = fl;
    fill_addr_i = fa;
    flush_i     = fs;
    e_valid = lk && !fl;  // Fill wins, lookup dropped
    e_way   = '0;
    if (e_valid && !fs) begin
      for (int w = 0; w < ICACHE_N_WAY; w++) begin
        e_way[w] = vld_m[la.index][w] && (tag_m[la.index][w] == la.tag);
      end
    end
    if (fl) begin
      tag_m[fa.index][ptr_m] = fa.tag;
      vld_m[fa.index][ptr_m] = 1'b1;
      ptr_m = (ptr_m + 1) % ICACHE_N_WAY;
    end
    if (fs) begin
      // Tag write survives, valid bits do not
      for (int s = 0; s < ICACHE_DEPTH; s++) begin
        for (int w = 0; w < ICACHE_N_WAY; w++) begin
          vld_m[s][w] = 1'b0;
        end
      end
    end
    o_valid     = exp_valid_q;
    o_hit       = exp_hit_q;
    o_way       = exp_way_q;
    exp_valid_q = e_valid;
    exp_hit_q   = |e_way;
    exp_way_q   = e_way;
    @(posedge clk_i);
    #1;
    check_equal(result_o.valid, o_valid, "result valid");
    if (o_valid) begin
      check_equal(result_o.hit, o_hit, "result hit");
      check_equal(result_o.way, o_way, "result way");
    end
  endtask

  task automatic idle();
    run_cycle(1'b0, '0, 1'b0, '0, 1'b0);
  endtask

  task automatic do_lookup(input itag_addr_t a);
    run_cycle(1'b1, a, 1'b0, '0, 1'b0);
  endtask

  task automatic do_fill(input itag_addr_t a);
    run_cycle(1'b0, '0, 1'b1, a, 1'b0);
  endtask

  task automatic drain();
    idle();
    idle();
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic report_test();
    $display("%s: %s, %0d errors", cur_test,
             (err_cnt == test_err_start) ? "ok" : "FAILED", err_cnt - test_err_start);
  endtask

  task automatic test_reset_state();
    start_test("reset_state");
    repeat (3) idle();  // No lookup, valid must stay low
    for (int i = 0; i < 8; i++) begin
      do_lookup(make_addr(rand_tag(), rand_index()));
    end
    drain();
    report_test();
  endtask

  task automatic test_fill_hit();
    logic [TAG_WIDTH-3:0] base;
    start_test("fill_hit");
    set_a = rand_index();
    base  = (TAG_WIDTH-2)'(rand_bits(TAG_WIDTH - 2));
    for (int i = 0; i < ICACHE_N_WAY; i++) begin
      tags_a[i] = {base, 2'(i)};
      do_fill(make_addr(tags_a[i], set_a));
    end
    // First lookup lands right after the last fill
    for (int i = 0; i < ICACHE_N_WAY; i++) begin
      do_lookup(make_addr(tags_a[i], set_a));
    end
    do_lookup(make_addr({~base, 2'b00}, set_a));  // Fifth tag
    drain();
    report_test();
  endtask

  task automatic test_replacement();
    logic [TAG_WIDTH-1:0] old_tag;
    logic [TAG_WIDTH-1:0] new_tag;
    start_test("replacement");
    old_tag = tag_m[set_a][ptr_m];
    new_tag = {~tags_a[0][TAG_WIDTH-1:2], 2'b01};
    do_fill(make_addr(new_tag, set_a));
    do_lookup(make_addr(old_tag, set_a));
    do_lookup(make_addr(new_tag, set_a));
    drain();
    report_test();
  endtask

  task automatic test_pipelined();
    itag_addr_t filled [$];
    itag_addr_t a;
    start_test("pipelined");
    repeat (6) begin
      a = make_addr(rand_tag(), rand_index());
      do_fill(a);
      filled.push_back(a);
    end
    // Back to back, mix of filled and random addresses
    for (int i = 0; i < 16; i++) begin
      if (rand_bits(1) == 1) begin
        a = filled[rand_bits(3) % filled.size()];
      end else begin
        a = make_addr(rand_tag(), rand_index());
      end
      do_lookup(a);
    end
    drain();
    report_test();
  endtask

  task automatic test_flush();
    itag_addr_t fl_q [$];
    itag_addr_t a;
    start_test("flush");
    repeat (4) begin
      a = make_addr(rand_tag(), rand_index());
      do_fill(a);
      fl_q.push_back(a);
    end
    run_cycle(1'b1, fl_q[0], 1'b0, '0, 1'b1);  // Lookup beside the flush
    foreach (fl_q[i]) begin
      do_lookup(fl_q[i]);
    end
    a = make_addr(rand_tag(), rand_index());
    do_fill(a);
    do_lookup(a);
    drain();
    report_test();
  endtask

  task automatic test_fill_priority();
    itag_addr_t fa;
    itag_addr_t la;
    start_test("fill_priority");
    fa = make_addr(rand_tag(), rand_index());
    la = make_addr(rand_tag(), rand_index());
    run_cycle(1'b1, la, 1'b1, fa, 1'b0);
    idle();
    do_lookup(fa);
    drain();
    report_test();
  endtask

  initial begin
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    lookup_i    = 1'b0;
    addr_i      = '0;
    fill_i      = 1'b0;
    fill_addr_i = '0;
    flush_i     = 1'b0;
    lfsr_state  = 32'h37bc;
    pass_cnt    = 0;
    err_cnt     = 0;
    ptr_m       = 0;
    cur_test    = "init";
    for (int s = 0; s < ICACHE_DEPTH; s++) begin
      for (int w = 0; w < ICACHE_N_WAY; w++) begin
        tag_m[s][w] = '0;
        vld_m[s][w] = 1'b0;
      end
    end
    exp_valid_q = 1'b0;
    exp_hit_q   = 1'b0;
    exp_way_q   = '0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    test_reset_state();
    test_fill_hit();
    test_replacement();
    test_pipelined();
    test_flush();
    test_fill_priority();

    $display("Checks passed: %0d, errors: %0d", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0t, tests did not complete", $time);
    $display("Verification failed");
    $finish;
  end

endmodule
